// File: list.f
logic/bus_pkg.sv
logic/memory_pkg.sv
logic/host_bus_slave.sv
logic/waveform_memory.sv
logic/playback_sequencer.sv
logic/function_generator_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: logic/bus_pkg.sv
/*
 * host bus definitions
 * widths of the parallel host bus, halfword and word types, memory write record
 */
`default_nettype none

package bus_pkg;

	// ------------------------------------------------------------
	// host bus geometry
	localparam int BUS_WIDTH         = 16;
	localparam int HALVES_PER_WORD   = 2; // most significant half travels first
	localparam int SYNC_STAGES       = 3; // flops per host input
	localparam int ERROR_COUNT_WIDTH = 8;

	typedef logic [BUS_WIDTH-1:0]                 halfword_t;
	typedef logic [HALVES_PER_WORD*BUS_WIDTH-1:0] data_word_t;
	typedef logic [9:0]                           word_addr_t;
	typedef logic [ERROR_COUNT_WIDTH-1:0]         error_count_t;

	// position of a halfword inside the word being moved
	typedef logic [$clog2(HALVES_PER_WORD)-1:0] half_index_t;
	localparam half_index_t LAST_HALF = half_index_t'(HALVES_PER_WORD - 1);

	// one memory write, strobe high for a single clock
	typedef struct packed {
		logic       strobe;
		word_addr_t address;
		data_word_t data;
	} mem_write_t;

endpackage

`default_nettype wire

// File: logic/function_generator_top.sv
/*
 * function generator top level
 * host bus slave fills the waveform memory, the sequencer plays it back
 */
`timescale 1ns/1ps
`default_nettype none

module function_generator_top
	import bus_pkg::*, memory_pkg::*;
(
	input  wire logic    clock,
	input  wire logic    reset125,
	input  halfword_t    bus_in,
	input  wire logic    read,
	input  wire logic    register_select,
	input  wire logic    enable,
	output halfword_t    bus_out,
	output logic         ack_valid,
	output sample_t      sample,
	output logic         sync_out,
	output error_count_t protocol_errors
);

	mem_write_t mem_write;
	word_addr_t word_address;
	data_word_t read_word;
	byte_addr_t sample_address;

	// ------------------------------------------------------------
	host_bus_slave host_bus_slave_inst (
		.clock           (clock),
		.reset125        (reset125),
		.bus_in          (bus_in),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.read_word       (read_word),
		.bus_out         (bus_out),
		.ack_valid       (ack_valid),
		.mem_write       (mem_write),
		.word_address    (word_address),
		.protocol_errors (protocol_errors)
	);

	waveform_memory waveform_memory_inst (
		.clock          (clock),
		.mem_write      (mem_write),
		.word_address   (word_address),
		.sample_address (sample_address),
		.read_word      (read_word),
		.sample         (sample)
	);

	playback_sequencer playback_sequencer_inst (
		.clock          (clock),
		.reset125       (reset125),
		.sample_address (sample_address),
		.sync_out       (sync_out)
	);

endmodule

`default_nettype wire

// File: logic/host_bus_slave.sv
/*
 * host bus slave
 * synchronizes the host strobes, loads the word address, builds and reads back
 * 32-bit words as two halfwords and counts discarded partial words
 */
`timescale 1ns/1ps
`default_nettype none

module host_bus_slave
	import bus_pkg::*;
(
	input  wire logic   clock,
	input  wire logic   reset125,
	input  halfword_t   bus_in,
	input  wire logic   read,            // 1 read, 0 write
	input  wire logic   register_select, // 1 data, 0 address
	input  wire logic   enable,
	input  data_word_t  read_word,
	output halfword_t   bus_out,
	output logic        ack_valid,
	output mem_write_t  mem_write,
	output word_addr_t  word_address,
	output error_count_t protocol_errors
);

	typedef enum logic {
		ACCESS_IDLE,
		ACCESS_HELD // halfword accepted, waiting for enable to drop
	} access_state_t;

	// ------------------------------------------------------------
	// input synchronizers
	logic [SYNC_STAGES-1:0]        enable_sync;
	logic [SYNC_STAGES-1:0]        read_sync;
	logic [SYNC_STAGES-1:0]        select_sync;
	halfword_t [SYNC_STAGES-1:0]   bus_sync;

	always_ff @(posedge clock) begin
		if (reset125) begin
			enable_sync <= '0;
			read_sync   <= '0;
			select_sync <= '0;
		end else begin
			enable_sync <= {enable_sync[SYNC_STAGES-2:0], enable};
			read_sync   <= {read_sync[SYNC_STAGES-2:0], read};
			select_sync <= {select_sync[SYNC_STAGES-2:0], register_select};
		end
	end

	logic enable_high;
	logic enable_low;
	logic read_stable;
	logic select_stable;
	logic read_now;
	logic select_now;
	halfword_t bus_now;

	assign enable_high   = &enable_sync[SYNC_STAGES-1 -: 2];
	assign enable_low    = ~|enable_sync[SYNC_STAGES-1 -: 2];
	assign read_stable   = read_sync[SYNC_STAGES-1] == read_sync[SYNC_STAGES-2];
	assign select_stable = select_sync[SYNC_STAGES-1] == select_sync[SYNC_STAGES-2];
	assign read_now      = read_sync[SYNC_STAGES-1];
	assign select_now    = select_sync[SYNC_STAGES-1];
	assign bus_now       = bus_sync[SYNC_STAGES-1];

	// ------------------------------------------------------------
	// strobe decode
	access_state_t addr_state;
	access_state_t write_state;
	access_state_t read_state;
	half_index_t   write_index;
	half_index_t   read_index;
	logic          accept;
	logic          complete;
	logic          partial_lost;

	assign accept   = enable_high && read_stable && select_stable && !ack_valid;
	assign complete = enable_low && ack_valid;

	// a different kind of access finishes on top of a half-built word
	assign partial_lost = complete && (
		(write_state == ACCESS_HELD && read_index != '0) ||
		(read_state == ACCESS_HELD && write_index != '0) ||
		(addr_state == ACCESS_HELD && (write_index != '0 || read_index != '0)));

	// ------------------------------------------------------------
	// captured halfwords
	data_word_t write_word;
	word_addr_t address_buffer;
	halfword_t  read_half;

	assign read_half = read_word[(HALVES_PER_WORD-1-read_index)*BUS_WIDTH +: BUS_WIDTH];

	always_ff @(posedge clock) begin
		bus_sync <= {bus_sync[SYNC_STAGES-2:0], bus_in};
		if (accept && !read_now) begin
			if (select_now) begin
				write_word[(HALVES_PER_WORD-1-write_index)*BUS_WIDTH +: BUS_WIDTH] <= bus_now;
			end else begin
				address_buffer <= bus_now[$bits(word_addr_t)-1:0];
			end
		end
	end

	// ------------------------------------------------------------
	// access state machines
	always_ff @(posedge clock) begin
		if (reset125) begin
			ack_valid        <= 1'b0;
			mem_write.strobe <= 1'b0;
			word_address     <= '0;
			protocol_errors  <= '0;
			bus_out          <= '0;
			addr_state       <= ACCESS_IDLE;
			write_state      <= ACCESS_IDLE;
			read_state       <= ACCESS_IDLE;
			write_index      <= '0;
			read_index       <= '0;
		end else begin
			mem_write.strobe <= 1'b0;
			if (accept) begin
				ack_valid <= 1'b1;
				if (read_now) begin // reads always return data
					read_state <= ACCESS_HELD;
					bus_out    <= read_half;
				end else if (select_now) begin
					write_state <= ACCESS_HELD;
				end else begin
					addr_state <= ACCESS_HELD;
				end
			end else if (complete) begin
				ack_valid   <= 1'b0;
				addr_state  <= ACCESS_IDLE;
				write_state <= ACCESS_IDLE;
				read_state  <= ACCESS_IDLE;
				if (partial_lost && protocol_errors != '1) begin
					protocol_errors <= protocol_errors + 1'b1; // saturates
				end
				if (write_state == ACCESS_HELD) begin
					read_index <= '0;
					if (write_index == LAST_HALF) begin
						mem_write.strobe  <= 1'b1;
						mem_write.address <= word_address;
						mem_write.data    <= write_word;
						word_address      <= word_address + 1'b1;
						write_index       <= '0;
					end else begin
						write_index <= write_index + 1'b1;
					end
				end
				if (read_state == ACCESS_HELD) begin
					write_index <= '0;
					if (read_index == LAST_HALF) begin
						word_address <= word_address + 1'b1;
						read_index   <= '0;
					end else begin
						read_index <= read_index + 1'b1;
					end
				end
				if (addr_state == ACCESS_HELD) begin
					word_address <= address_buffer;
					write_index  <= '0;
					read_index   <= '0;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// checks
	ack_drops_after_enable: assert property (@(posedge clock) disable iff (reset125)
		enable_low && $past(enable_low) |-> !ack_valid);

	write_strobe_single: assert property (@(posedge clock) disable iff (reset125)
		mem_write.strobe |=> !mem_write.strobe);

endmodule

`default_nettype wire

// File: logic/memory_pkg.sv
/*
 * waveform memory definitions
 * memory geometry, byte addressing and the playback loop region
 */
`default_nettype none

package memory_pkg;
	import bus_pkg::*;

	localparam int MEMORY_WORDS     = 2 ** $bits(word_addr_t); // 1024
	localparam int BYTES_PER_WORD   = 4;
	localparam int BYTE_SELECT_BITS = $clog2(BYTES_PER_WORD);

	typedef logic [7:0]                                        sample_t;
	typedef logic [$bits(word_addr_t)+BYTE_SELECT_BITS-1:0]    byte_addr_t; // 12 bits

	// ------------------------------------------------------------
	// playback loop
	localparam byte_addr_t PLAYBACK_FIRST = '0;
	localparam int         PLAYBACK_BYTES = 256;
	localparam byte_addr_t PLAYBACK_LAST  = byte_addr_t'(PLAYBACK_FIRST + PLAYBACK_BYTES - 1);

endpackage

`default_nettype wire

// File: logic/playback_sequencer.sv
/*
 * playback sequencer
 * loops the byte read address over the playback region, marks each loop start
 */
`timescale 1ns/1ps
`default_nettype none

module playback_sequencer
	import memory_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset125,
	output byte_addr_t sample_address,
	output logic       sync_out
);

	logic loop_start;

	assign loop_start = sample_address == PLAYBACK_FIRST;

	always_ff @(posedge clock) begin
		if (reset125) begin
			sample_address <= PLAYBACK_FIRST;
			sync_out       <= 1'b0;
		end else begin
			if (sample_address == PLAYBACK_LAST) begin
				sample_address <= PLAYBACK_FIRST; // wrap to loop start
			end else begin
				sample_address <= sample_address + 1'b1;
			end
			sync_out <= loop_start; // matches the memory read latency
		end
	end

	// sync only follows the first byte of the loop
	sync_after_first: assert property (@(posedge clock) disable iff (reset125)
		sync_out |-> $past(sample_address) == PLAYBACK_FIRST);

endmodule

`default_nettype wire

// File: logic/waveform_memory.sv
/*
 * waveform memory
 * dual-port word array, 32-bit host port and byte-wide playback port
 */
`timescale 1ns/1ps
`default_nettype none

module waveform_memory
	import bus_pkg::*, memory_pkg::*;
(
	input  wire logic  clock,
	input  mem_write_t mem_write,
	input  word_addr_t word_address,
	input  byte_addr_t sample_address,
	output data_word_t read_word,
	output sample_t    sample
);

	data_word_t memory [MEMORY_WORDS];

	// ------------------------------------------------------------
	// host port
	always_ff @(posedge clock) begin
		if (mem_write.strobe) begin
			memory[mem_write.address] <= mem_write.data;
		end
		read_word <= memory[word_address]; // one cycle latency
	end

	// ------------------------------------------------------------
	// playback port
	word_addr_t                  sample_word;
	logic [BYTE_SELECT_BITS-1:0] sample_lane;

	assign sample_word = sample_address[$bits(byte_addr_t)-1:BYTE_SELECT_BITS];
	assign sample_lane = sample_address[BYTE_SELECT_BITS-1:0]; // byte 0 is the low byte

	always_ff @(posedge clock) begin
		sample <= memory[sample_word][sample_lane*$bits(sample_t) +: $bits(sample_t)];
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_top -f list.f; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_top 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'ALL CHECKS PASSED'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: testbench/tb_checker.sv
/*
 * testbench checker
 * decodes host strobes, keeps a memory and address model, compares DUT outputs
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
	import bus_pkg::*, memory_pkg::*;
(
	input  wire logic         clock,
	input  wire logic         reset125,
	input  wire halfword_t    bus_in,
	input  wire logic         read,
	input  wire logic         register_select,
	input  wire logic         enable,
	input  wire halfword_t    bus_out,
	input  wire logic         ack_valid,
	input  wire sample_t      sample,
	input  wire logic         sync_out,
	input  wire error_count_t protocol_errors,
	input  wire logic [7:0]   test_id,
	input  wire logic         check_playback,
	output int                error_count
);

	data_word_t   model_memory [MEMORY_WORDS];
	word_addr_t   model_address = '0;
	data_word_t   pending_word = '0;
	int           write_half = 0;
	int           read_half = 0;
	error_count_t expected_errors = '0;
	logic         ack_seen = 1'b0;
	logic         in_reset = 1'b1;
	logic         captured_read = 1'b0;
	logic         captured_select = 1'b0;
	halfword_t    captured_bus = '0;
	int           position = 0; // byte offset inside the playback loop
	int           syncs_seen = 0;
	int           errors = 0;

	assign error_count = errors;

	function automatic string test_label(input logic [7:0] id);
		case (id)
			8'd1: return "reset_and_handshake";
			8'd2: return "write_then_read";
			8'd3: return "auto_increment";
			8'd4: return "playback";
			8'd5: return "protocol_error";
			default: return "unknown_test";
		endcase
	endfunction

	// expected halfword (host port) or sample byte (playback port) at an index
	function automatic halfword_t reference_value(input logic sample_port, input int index);
		data_word_t word;
		int         lane;
		if (sample_port) begin
			word = model_memory[word_addr_t'(index / BYTES_PER_WORD)];
			lane = index % BYTES_PER_WORD; // byte 0 is the low byte
			return halfword_t'(sample_t'(word >> ($bits(sample_t) * lane)));
		end
		word = model_memory[word_addr_t'(index / HALVES_PER_WORD)];
		lane = index % HALVES_PER_WORD;
		return halfword_t'(word >> (BUS_WIDTH * (HALVES_PER_WORD - 1 - lane)));
	endfunction

	task automatic compare_value(input string what, input halfword_t expected,
			input halfword_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %h, actual %h",
				test_label(test_id), what, expected, actual);
			errors++;
		end
	endtask

	task automatic count_lost_word();
		if (expected_errors != '1) begin
			expected_errors = expected_errors + 1'b1;
		end
	endtask

	// model of a completed strobe
	task automatic apply_strobe();
		if (captured_read) begin
			if (write_half != 0) begin
				count_lost_word();
				write_half = 0;
			end
			if (read_half == HALVES_PER_WORD - 1) begin
				model_address = model_address + 1'b1;
				read_half = 0;
			end else begin
				read_half = read_half + 1;
			end
		end else if (captured_select) begin
			if (read_half != 0) begin
				count_lost_word();
				read_half = 0;
			end
			if (write_half == 0) begin
				pending_word = {captured_bus, halfword_t'(0)};
				write_half = 1;
			end else begin
				pending_word = {pending_word[31:16], captured_bus};
				model_memory[model_address] = pending_word;
				model_address = model_address + 1'b1;
				write_half = 0;
			end
		end else begin
			if (write_half != 0 || read_half != 0) begin
				count_lost_word();
			end
			model_address = word_addr_t'(captured_bus);
			write_half = 0;
			read_half = 0;
		end
	endtask

	// ------------------------------------------------------------
	// comparing process
	always @(posedge clock) begin
		if (reset125) begin
			in_reset = 1'b1;
		end else begin
			if (in_reset) begin // first cycle out of reset
				compare_value("ack_valid after reset", '0, halfword_t'(ack_valid));
				compare_value("sync_out after reset", '0, halfword_t'(sync_out));
				compare_value("protocol_errors after reset", '0, halfword_t'(protocol_errors));
				compare_value("bus_out after reset", '0, bus_out);
				in_reset = 1'b0;
			end
			if (enable && ack_valid && !ack_seen) begin
				captured_read   = read;
				captured_select = register_select;
				captured_bus    = bus_in;
				if (read) begin
					compare_value("read halfword", reference_value(1'b0,
						int'(model_address) * HALVES_PER_WORD + read_half), bus_out);
				end
				ack_seen = 1'b1;
			end else if (!ack_valid && ack_seen) begin
				apply_strobe();
				compare_value("protocol_errors", halfword_t'(expected_errors),
					halfword_t'(protocol_errors));
				ack_seen = 1'b0;
			end
			if (check_playback) begin
				if (sync_out) begin
					if (syncs_seen > 0 && position != PLAYBACK_BYTES) begin
						$display("sync_out came %0d cycles after the previous pulse, not %0d",
							position, PLAYBACK_BYTES);
						errors++;
					end
					position = 0;
					syncs_seen++;
				end else if (syncs_seen > 0 && position == PLAYBACK_BYTES) begin
					$display("sync_out missing at the end of the playback loop");
					errors++;
				end
				if (syncs_seen > 0) begin
					if (position < PLAYBACK_BYTES) begin
						compare_value("sample", reference_value(1'b1,
							int'(PLAYBACK_FIRST) + position), halfword_t'(sample));
					end
					position++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
/*
 * testbench clock and reset
 * 4 ns clock, reset125 held high for the first 10 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset125
);

	localparam int HALF_PERIOD  = 2; // ns
	localparam int RESET_CYCLES = 10;

	initial begin
		clock = 1'b0;
		reset125 <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset125 <= 1'b0; // released on a rising edge
	end

	always #HALF_PERIOD clock = ~clock;

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
/*
 * testbench top
 * drives host bus transfers into the function generator and runs the test sequence
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top
	import bus_pkg::*, memory_pkg::*;
();

	localparam int          ACK_TIMEOUT   = 20;
	localparam int          SYNC_TIMEOUT  = 2 * PLAYBACK_BYTES + 8;
	localparam int          RESET_TIMEOUT = 40;
	localparam logic [31:0] SEED          = 32'h0715479e;

	logic         clock;
	logic         reset125;
	halfword_t    bus_in;
	logic         read;
	logic         register_select;
	logic         enable;
	halfword_t    bus_out;
	logic         ack_valid;
	sample_t      sample;
	logic         sync_out;
	error_count_t protocol_errors;
	logic [7:0]   test_id;
	logic         check_playback;
	int           error_count;
	int           timeout_count = 0;
	logic [31:0]  rand_state = SEED;

	tb_clock_gen clock_gen_inst (
		.clock    (clock),
		.reset125 (reset125)
	);

	function_generator_top function_generator_top_inst (
		.clock           (clock),
		.reset125        (reset125),
		.bus_in          (bus_in),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.bus_out         (bus_out),
		.ack_valid       (ack_valid),
		.sample          (sample),
		.sync_out        (sync_out),
		.protocol_errors (protocol_errors)
	);

	tb_checker checker_inst (
		.clock           (clock),
		.reset125        (reset125),
		.bus_in          (bus_in),
		.read            (read),
		.register_select (register_select),
		.enable          (enable),
		.bus_out         (bus_out),
		.ack_valid       (ack_valid),
		.sample          (sample),
		.sync_out        (sync_out),
		.protocol_errors (protocol_errors),
		.test_id         (test_id),
		.check_playback  (check_playback),
		.error_count     (error_count)
	);

	// ------------------------------------------------------------
	// helpers
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random_word(output data_word_t word);
		rand_state = lcg_next(rand_state);
		word = rand_state;
	endtask

	task automatic end_simulation();
		$display("closing counts: checker errors %0d, timeouts %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	// after a first timeout the remaining waits fall straight through
	task automatic wait_ack(input logic level);
		int   cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < ACK_TIMEOUT && timeout_count == 0) begin
			@(posedge clock);
			seen = (ack_valid === level);
			cycles++;
		end
		if (!seen && timeout_count == 0) begin
			$display("timeout: ack_valid did not go to %0b within %0d cycles", level, ACK_TIMEOUT);
			timeout_count++;
		end
	endtask

	task automatic find_sync();
		int   cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < SYNC_TIMEOUT && timeout_count == 0) begin
			@(posedge clock);
			seen = (sync_out === 1'b1);
			cycles++;
		end
		if (!seen && timeout_count == 0) begin
			$display("timeout: no sync_out pulse within %0d cycles", SYNC_TIMEOUT);
			timeout_count++;
		end
	endtask

	task automatic leave_reset();
		int   cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < RESET_TIMEOUT && timeout_count == 0) begin
			@(posedge clock);
			done = (reset125 === 1'b0);
			cycles++;
		end
		if (!done && timeout_count == 0) begin
			$display("timeout: reset125 was never released");
			timeout_count++;
		end
	endtask

	// one full handshake: set up, raise enable, wait ack, drop, wait ack low
	task automatic host_strobe(input logic read_strobe, input logic data_select,
			input halfword_t value);
		@(posedge clock);
		bus_in          <= value;
		read            <= read_strobe;
		register_select <= data_select;
		@(posedge clock);
		enable <= 1'b1;
		wait_ack(1'b1);
		enable <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic write_address(input word_addr_t address);
		host_strobe(1'b0, 1'b0, halfword_t'(address));
	endtask

	task automatic write_word(input data_word_t word);
		host_strobe(1'b0, 1'b1, word[31:16]); // high half first
		host_strobe(1'b0, 1'b1, word[15:0]);
	endtask

	task automatic read_word_back();
		host_strobe(1'b1, 1'b1, '0);
		host_strobe(1'b1, 1'b1, '0);
	endtask

	task automatic start_test(input logic [7:0] id);
		@(posedge clock);
		test_id <= id;
	endtask

	// ------------------------------------------------------------
	// test sequence
	initial begin
		data_word_t word;
		bus_in          <= '0;
		read            <= 1'b0;
		register_select <= 1'b0;
		enable          <= 1'b0;
		check_playback  <= 1'b0;
		test_id         <= 8'd1;
		leave_reset();

		// reset values are checked by the checker, here only handshakes
		write_address(10'h000);
		write_address(10'h3ff);

		start_test(8'd2);
		next_random_word(word);
		write_address(10'h040);
		write_word(word);
		write_address(10'h040);
		read_word_back();

		start_test(8'd3);
		write_address(10'h100);
		for (int i = 0; i < 8; i++) begin
			next_random_word(word);
			write_word(word);
		end
		write_address(10'h100);
		for (int i = 0; i < 8; i++) begin
			read_word_back();
		end

		start_test(8'd4);
		write_address(word_addr_t'(PLAYBACK_FIRST / BYTES_PER_WORD));
		for (int i = 0; i < PLAYBACK_BYTES / BYTES_PER_WORD; i++) begin
			next_random_word(word);
			write_word(word);
		end
		repeat (4) @(posedge clock); // let the last write land
		check_playback <= 1'b1;
		find_sync();
		find_sync(); // checker measures the spacing
		check_playback <= 1'b0;

		// half a word then an address write drops the half
		start_test(8'd5);
		write_address(10'h102);
		next_random_word(word);
		host_strobe(1'b0, 1'b1, word[31:16]);
		write_address(10'h102);
		read_word_back();

		repeat (2) @(posedge clock);
		end_simulation();
	end

endmodule

`default_nettype wire
